// File: radio_config.svh
// Board settings-bus configuration: register map, widths and reset values
`ifndef RADIO_CONFIG_SVH
`define RADIO_CONFIG_SVH

// Settings bus word sizes
`define SET_ADDR_W 8
`define SET_DATA_W 32

// Board control register block
`define SR_MISC_BASE   0
`define SR_CLK_OFS     0
`define SR_SER_OFS     1
`define SR_ADC_OFS     2
`define SR_LED_OFS     3
`define SR_PHY_OFS     4
`define SR_LED_SRC_OFS 6

// VITA time registers
`define SR_TIME64_BASE     10
`define SR_TIME_HI_OFS     0
`define SR_TIME_LO_NOW_OFS 1
`define SR_TIME_LO_PPS_OFS 2

// LEDs 1 to 4 on hardware status out of reset
`define LED_W         8
`define LED_SRC_RESET 8'h1E

// Major in the upper half, minor in the lower half
`define COMPAT_NUM {16'd9, 16'd0}
`define RB_SEL_W   4

`endif

// File: radio_pkg.sv
// Shared settings-bus types: data word views and register write enables
`include "radio_config.svh"

package radio_pkg;

   // Same data word, read by field according to the target register
   typedef union packed {
      logic [`SET_DATA_W-1:0] raw;
      struct packed {
         logic [`SET_DATA_W-6:0] unused;
         logic                   clock_ready;
         logic [1:0]             clk_en;
         logic [1:0]             clk_sel;
      } clk;
      struct packed {
         logic [`SET_DATA_W-5:0] unused;
         logic                   enable;
         logic                   prbsen;
         logic                   loopen;
         logic                   rx_en;
      } ser;
      struct packed {
         logic [`SET_DATA_W-5:0] unused;
         logic                   oe_a;
         logic                   on_a;
         logic                   oe_b;
         logic                   on_b;
      } adc;
   } set_data_u;

   // Bit positions inside the write enable vector
   localparam int unsigned we_clk         = 0;
   localparam int unsigned we_ser         = 1;
   localparam int unsigned we_adc         = 2;
   localparam int unsigned we_led         = 3;
   localparam int unsigned we_phy         = 4;
   localparam int unsigned we_led_src     = 5;
   localparam int unsigned we_time_hi     = 6;
   localparam int unsigned we_time_lo_now = 7;
   localparam int unsigned we_time_lo_pps = 8;
   localparam int unsigned we_count       = 9;

   typedef logic [we_count-1:0] set_we_t;

endpackage

// File: settings_ctrl.sv
// Settings write arbiter for host and command sources, with address decode
`include "radio_config.svh"

module settings_ctrl (
   input  logic                   dsp_clk,
   input  logic                   por_rst,
   input  logic                   host_stb_i,
   input  logic [`SET_ADDR_W-1:0] host_addr_i,
   input  logic [`SET_DATA_W-1:0] host_data_i,
   input  logic                   cmd_stb_i,
   input  logic [`SET_ADDR_W-1:0] cmd_addr_i,
   input  logic [`SET_DATA_W-1:0] cmd_data_i,
   output radio_pkg::set_we_t     set_we_o,
   output radio_pkg::set_data_u   set_data_o
);

   localparam logic [`SET_ADDR_W-1:0] addr_clk = `SET_ADDR_W'(`SR_MISC_BASE + `SR_CLK_OFS);
   localparam logic [`SET_ADDR_W-1:0] addr_ser = `SET_ADDR_W'(`SR_MISC_BASE + `SR_SER_OFS);
   localparam logic [`SET_ADDR_W-1:0] addr_adc = `SET_ADDR_W'(`SR_MISC_BASE + `SR_ADC_OFS);
   localparam logic [`SET_ADDR_W-1:0] addr_led = `SET_ADDR_W'(`SR_MISC_BASE + `SR_LED_OFS);
   localparam logic [`SET_ADDR_W-1:0] addr_phy = `SET_ADDR_W'(`SR_MISC_BASE + `SR_PHY_OFS);
   localparam logic [`SET_ADDR_W-1:0] addr_led_src =
      `SET_ADDR_W'(`SR_MISC_BASE + `SR_LED_SRC_OFS);
   localparam logic [`SET_ADDR_W-1:0] addr_time_hi =
      `SET_ADDR_W'(`SR_TIME64_BASE + `SR_TIME_HI_OFS);
   localparam logic [`SET_ADDR_W-1:0] addr_time_lo_now =
      `SET_ADDR_W'(`SR_TIME64_BASE + `SR_TIME_LO_NOW_OFS);
   localparam logic [`SET_ADDR_W-1:0] addr_time_lo_pps =
      `SET_ADDR_W'(`SR_TIME64_BASE + `SR_TIME_LO_PPS_OFS);

   logic                   host_pend;
   logic [`SET_ADDR_W-1:0] pend_addr;
   logic [`SET_DATA_W-1:0] pend_data;

   logic                   win_stb;
   logic [`SET_ADDR_W-1:0] win_addr;
   logic [`SET_DATA_W-1:0] win_data;

   ////////////////////////////////////////////////////////////
   // Arbitration, command source first

   // Host write that collides waits here for one cycle
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         host_pend <= 1'b0;
      end else begin
         host_pend <= cmd_stb_i & (host_stb_i | host_pend);
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (cmd_stb_i && host_stb_i) begin
         pend_addr <= host_addr_i;
         pend_data <= host_data_i;
      end
   end

   always_comb begin
      win_stb = cmd_stb_i | host_pend | host_stb_i;
      if (cmd_stb_i) begin
         win_addr = cmd_addr_i;
         win_data = cmd_data_i;
      end else if (host_pend) begin
         win_addr = pend_addr;
         win_data = pend_data;
      end else begin
         win_addr = host_addr_i;
         win_data = host_data_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // Address decode

   always_comb begin
      set_we_o = '0;
      if (win_stb) begin
         case (win_addr)
            addr_clk:         set_we_o[radio_pkg::we_clk] = 1'b1;
            addr_ser:         set_we_o[radio_pkg::we_ser] = 1'b1;
            addr_adc:         set_we_o[radio_pkg::we_adc] = 1'b1;
            addr_led:         set_we_o[radio_pkg::we_led] = 1'b1;
            addr_phy:         set_we_o[radio_pkg::we_phy] = 1'b1;
            addr_led_src:     set_we_o[radio_pkg::we_led_src] = 1'b1;
            addr_time_hi:     set_we_o[radio_pkg::we_time_hi] = 1'b1;
            addr_time_lo_now: set_we_o[radio_pkg::we_time_lo_now] = 1'b1;
            addr_time_lo_pps: set_we_o[radio_pkg::we_time_lo_pps] = 1'b1;
            default:          set_we_o = '0;
         endcase
      end
   end

   assign set_data_o.raw = win_data;

   // At most one register written per cycle
   assert property (@(posedge dsp_clk) disable iff (por_rst) $onehot0(set_we_o));

   // Host keeps its two-cycle spacing, so a held write never gets overrun
   assert property (@(posedge dsp_clk) disable iff (por_rst) host_pend |-> !host_stb_i);

endmodule

// File: misc_regs.sv
// Board control registers for clocks, serdes, ADC, PHY reset and LEDs
`include "radio_config.svh"

module misc_regs (
   input  logic                 dsp_clk,
   input  logic                 por_rst,
   input  radio_pkg::set_we_t   set_we_i,
   input  radio_pkg::set_data_u set_data_i,
   input  logic                 run_tx_i,
   input  logic                 run_rx_i,
   input  logic                 clk_status_i,
   input  logic                 link_up_i,
   output logic                 clock_ready_o,
   output logic [1:0]           clk_en_o,
   output logic [1:0]           clk_sel_o,
   output logic                 ser_enable_o,
   output logic                 ser_prbsen_o,
   output logic                 ser_loopen_o,
   output logic                 ser_rx_en_o,
   output logic                 adc_oe_a_o,
   output logic                 adc_on_a_o,
   output logic                 adc_oe_b_o,
   output logic                 adc_on_b_o,
   output logic                 phy_reset_n_o,
   output logic [`LED_W-1:0]    leds_o
);

   logic              phy_reset;
   logic [`LED_W-1:0] led_sw;
   logic [`LED_W-1:0] led_src;
   logic [`LED_W-1:0] led_hw;

   ////////////////////////////////////////////////////////////
   // Control registers
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clock_ready_o <= 1'b0;
         clk_en_o      <= 2'b00;
         clk_sel_o     <= 2'b00;
         ser_enable_o  <= 1'b0;
         ser_prbsen_o  <= 1'b0;
         ser_loopen_o  <= 1'b0;
         ser_rx_en_o   <= 1'b0;
         adc_oe_a_o    <= 1'b0;
         adc_on_a_o    <= 1'b0;
         adc_oe_b_o    <= 1'b0;
         adc_on_b_o    <= 1'b0;
         phy_reset     <= 1'b0;
         led_sw        <= '0;
         led_src       <= `LED_SRC_RESET;
      end else begin
         if (set_we_i[radio_pkg::we_clk]) begin
            clock_ready_o <= set_data_i.clk.clock_ready;
            clk_en_o      <= set_data_i.clk.clk_en;
            clk_sel_o     <= set_data_i.clk.clk_sel;
         end
         if (set_we_i[radio_pkg::we_ser]) begin
            ser_enable_o <= set_data_i.ser.enable;
            ser_prbsen_o <= set_data_i.ser.prbsen;
            ser_loopen_o <= set_data_i.ser.loopen;
            ser_rx_en_o  <= set_data_i.ser.rx_en;
         end
         if (set_we_i[radio_pkg::we_adc]) begin
            adc_oe_a_o <= set_data_i.adc.oe_a;
            adc_on_a_o <= set_data_i.adc.on_a;
            adc_oe_b_o <= set_data_i.adc.oe_b;
            adc_on_b_o <= set_data_i.adc.on_b;
         end
         if (set_we_i[radio_pkg::we_phy]) begin
            phy_reset <= set_data_i.raw[0];
         end
         if (set_we_i[radio_pkg::we_led]) begin
            led_sw <= set_data_i.raw[`LED_W-1:0];
         end
         if (set_we_i[radio_pkg::we_led_src]) begin
            led_src <= set_data_i.raw[`LED_W-1:0];
         end
      end
   end

   // PHY reset pin is active low
   assign phy_reset_n_o = ~phy_reset;

   ////////////////////////////////////////////////////////////
   // LED source select, 1 picks hardware status per bit
   assign led_hw = {{(`LED_W-5){1'b0}}, run_tx_i, run_rx_i, clk_status_i, link_up_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   // Status LEDs owned by hardware as soon as reset lifts
   assert property (@(posedge dsp_clk) $fell(por_rst) |-> led_src == `LED_SRC_RESET);

endmodule

// File: vita_timer.sv
// 64-bit VITA time counter with immediate or PPS-timed load and PPS latch
`include "radio_config.svh"

module vita_timer (
   input  logic                 dsp_clk,
   input  logic                 por_rst,
   input  radio_pkg::set_we_t   set_we_i,
   input  radio_pkg::set_data_u set_data_i,
   input  logic                 pps_i,
   output logic [63:0]          vita_time_o,
   output logic [63:0]          vita_time_pps_o,
   output logic                 pps_seen_o
);

   // Two sync stages plus one for edge detection
   logic [2:0]             pps_sync;
   logic                   pps_edge;

   logic [`SET_DATA_W-1:0] time_hi;
   logic [63:0]            pps_load;
   logic                   pps_arm;
   logic                   load_now;
   logic                   load_pps;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_sync <= 3'b000;
      end else begin
         pps_sync <= {pps_sync[1:0], pps_i};
      end
   end

   assign pps_edge = pps_sync[1] & ~pps_sync[2];

   assign load_now = set_we_i[radio_pkg::we_time_lo_now];
   assign load_pps = pps_arm & pps_edge;

   ////////////////////////////////////////////////////////////
   // Staged high word and the armed PPS value
   always_ff @(posedge dsp_clk) begin
      if (set_we_i[radio_pkg::we_time_hi]) begin
         time_hi <= set_data_i.raw;
      end
      if (set_we_i[radio_pkg::we_time_lo_pps]) begin
         pps_load <= {time_hi, set_data_i.raw};
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_arm <= 1'b0;
      end else if (set_we_i[radio_pkg::we_time_lo_pps]) begin
         pps_arm <= 1'b1;
      end else if (load_pps) begin
         pps_arm <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Counter and PPS time latch
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
         pps_seen_o      <= 1'b0;
      end else begin
         if (load_now) begin
            vita_time_o <= {time_hi, set_data_i.raw};
         end else if (load_pps) begin
            vita_time_o <= pps_load;
         end else begin
            vita_time_o <= vita_time_o + 64'd1;
         end
         // On a timed load the latch holds the loaded time
         if (pps_edge) begin
            vita_time_pps_o <= load_pps ? pps_load : vita_time_o;
            pps_seen_o      <= 1'b1;
         end
      end
   end

   assert property (@(posedge dsp_clk) disable iff (por_rst) !(load_now && load_pps));

endmodule

// File: readback_mux.sv
// Registered sixteen-word readback of time, PPS time, version and status
`include "radio_config.svh"

module readback_mux (
   input  logic                   dsp_clk,
   input  logic                   por_rst,
   input  logic [`RB_SEL_W-1:0]   rb_sel_i,
   input  logic [63:0]            vita_time_i,
   input  logic [63:0]            vita_time_pps_i,
   input  logic                   clk_status_i,
   input  logic                   link_up_i,
   input  logic                   pps_seen_i,
   output logic [`SET_DATA_W-1:0] rb_data_o
);

   localparam logic [`RB_SEL_W-1:0] rb_time_hi     = `RB_SEL_W'(10);
   localparam logic [`RB_SEL_W-1:0] rb_time_lo     = `RB_SEL_W'(11);
   localparam logic [`RB_SEL_W-1:0] rb_compat      = `RB_SEL_W'(12);
   localparam logic [`RB_SEL_W-1:0] rb_flags       = `RB_SEL_W'(13);
   localparam logic [`RB_SEL_W-1:0] rb_pps_time_hi = `RB_SEL_W'(14);
   localparam logic [`RB_SEL_W-1:0] rb_pps_time_lo = `RB_SEL_W'(15);

   logic [`SET_DATA_W-1:0] flags;
   logic [`SET_DATA_W-1:0] rb_next;

   // Clock status in bit 12, link in bit 10, PPS seen in bit 0
   assign flags = {19'b0, clk_status_i, 1'b0, link_up_i, 9'b0, pps_seen_i};

   always_comb begin
      case (rb_sel_i)
         rb_time_hi:     rb_next = vita_time_i[63:32];
         rb_time_lo:     rb_next = vita_time_i[31:0];
         rb_compat:      rb_next = `COMPAT_NUM;
         rb_flags:       rb_next = flags;
         rb_pps_time_hi: rb_next = vita_time_pps_i[63:32];
         rb_pps_time_lo: rb_next = vita_time_pps_i[31:0];
         // Words of removed blocks
         default:        rb_next = '0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_data_o <= '0;
      end else begin
         rb_data_o <= rb_next;
      end
   end

endmodule

// File: radio_ctrl_top.sv
// Board settings-bus core: write arbitration, control registers, timer, readback
`include "radio_config.svh"

module radio_ctrl_top (
   input  logic                   dsp_clk,
   input  logic                   por_rst,
   // Settings write sources
   input  logic                   host_stb_i,
   input  logic [`SET_ADDR_W-1:0] host_addr_i,
   input  logic [`SET_DATA_W-1:0] host_data_i,
   input  logic                   cmd_stb_i,
   input  logic [`SET_ADDR_W-1:0] cmd_addr_i,
   input  logic [`SET_DATA_W-1:0] cmd_data_i,
   // Board status
   input  logic                   pps_i,
   input  logic                   clk_status_i,
   input  logic                   link_up_i,
   input  logic                   run_tx_i,
   input  logic                   run_rx_i,
   // Control lines
   output logic                   clock_ready_o,
   output logic [1:0]             clk_en_o,
   output logic [1:0]             clk_sel_o,
   output logic                   ser_enable_o,
   output logic                   ser_prbsen_o,
   output logic                   ser_loopen_o,
   output logic                   ser_rx_en_o,
   output logic                   adc_oe_a_o,
   output logic                   adc_on_a_o,
   output logic                   adc_oe_b_o,
   output logic                   adc_on_b_o,
   output logic                   phy_reset_n_o,
   output logic [`LED_W-1:0]      leds_o,
   // Readback
   input  logic [`RB_SEL_W-1:0]   rb_sel_i,
   output logic [`SET_DATA_W-1:0] rb_data_o
);

   radio_pkg::set_we_t   set_we;
   radio_pkg::set_data_u set_data;
   logic [63:0]          vita_time;
   logic [63:0]          vita_time_pps;
   logic                 pps_seen;

   settings_ctrl i_settings_ctrl (
      .dsp_clk, .por_rst,
      .host_stb_i, .host_addr_i, .host_data_i,
      .cmd_stb_i, .cmd_addr_i, .cmd_data_i,
      .set_we_o(set_we), .set_data_o(set_data)
   );

   misc_regs i_misc_regs (
      .dsp_clk, .por_rst,
      .set_we_i(set_we), .set_data_i(set_data),
      .run_tx_i, .run_rx_i, .clk_status_i, .link_up_i,
      .clock_ready_o, .clk_en_o, .clk_sel_o,
      .ser_enable_o, .ser_prbsen_o, .ser_loopen_o, .ser_rx_en_o,
      .adc_oe_a_o, .adc_on_a_o, .adc_oe_b_o, .adc_on_b_o,
      .phy_reset_n_o, .leds_o
   );

   vita_timer i_vita_timer (
      .dsp_clk, .por_rst,
      .set_we_i(set_we), .set_data_i(set_data), .pps_i,
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps), .pps_seen_o(pps_seen)
   );

   readback_mux i_readback_mux (
      .dsp_clk, .por_rst, .rb_sel_i,
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .clk_status_i, .link_up_i, .pps_seen_i(pps_seen),
      .rb_data_o
   );

endmodule

// File: radio_ctrl_tb.sv
// Self-checking testbench for the board settings-bus core driven from a stimulus table
`include "radio_config.svh"

module radio_ctrl_tb;

   localparam int clk_period = 100;
   localparam int max_rows   = 64;

   // Which source strobes in a row
   localparam logic [1:0] src_idle = 2'd0;
   localparam logic [1:0] src_host = 2'd1;
   localparam logic [1:0] src_cmd  = 2'd2;
   localparam logic [1:0] src_both = 2'd3;

   // How rb_data_o is compared
   localparam logic [1:0] rb_exact    = 2'd0;
   localparam logic [1:0] rb_window   = 2'd1;
   localparam logic [1:0] rb_at_least = 2'd2;

   localparam logic [`SET_ADDR_W-1:0] a_clk = `SET_ADDR_W'(`SR_MISC_BASE + `SR_CLK_OFS);
   localparam logic [`SET_ADDR_W-1:0] a_ser = `SET_ADDR_W'(`SR_MISC_BASE + `SR_SER_OFS);
   localparam logic [`SET_ADDR_W-1:0] a_adc = `SET_ADDR_W'(`SR_MISC_BASE + `SR_ADC_OFS);
   localparam logic [`SET_ADDR_W-1:0] a_led = `SET_ADDR_W'(`SR_MISC_BASE + `SR_LED_OFS);
   localparam logic [`SET_ADDR_W-1:0] a_phy = `SET_ADDR_W'(`SR_MISC_BASE + `SR_PHY_OFS);
   localparam logic [`SET_ADDR_W-1:0] a_led_src =
      `SET_ADDR_W'(`SR_MISC_BASE + `SR_LED_SRC_OFS);
   localparam logic [`SET_ADDR_W-1:0] a_time_hi =
      `SET_ADDR_W'(`SR_TIME64_BASE + `SR_TIME_HI_OFS);
   localparam logic [`SET_ADDR_W-1:0] a_time_lo_now =
      `SET_ADDR_W'(`SR_TIME64_BASE + `SR_TIME_LO_NOW_OFS);
   localparam logic [`SET_ADDR_W-1:0] a_time_lo_pps =
      `SET_ADDR_W'(`SR_TIME64_BASE + `SR_TIME_LO_PPS_OFS);

   logic                   dsp_clk = 1'b0;
   logic                   por_rst;
   logic                   host_stb_i, cmd_stb_i;
   logic [`SET_ADDR_W-1:0] host_addr_i, cmd_addr_i;
   logic [`SET_DATA_W-1:0] host_data_i, cmd_data_i;
   logic                   pps_i, clk_status_i, link_up_i, run_tx_i, run_rx_i;
   logic                   clock_ready_o, ser_enable_o, ser_prbsen_o, ser_loopen_o;
   logic                   ser_rx_en_o, adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o;
   logic                   phy_reset_n_o;
   logic [1:0]             clk_en_o, clk_sel_o;
   logic [`LED_W-1:0]      leds_o;
   logic [`RB_SEL_W-1:0]   rb_sel_i;
   logic [`SET_DATA_W-1:0] rb_data_o;

   ////////////////////////////////////////////////////////////
   // Stimulus table with one row per clock cycle

   logic [1:0]             row_src     [max_rows];
   logic [`SET_ADDR_W-1:0] row_haddr   [max_rows];
   logic [`SET_ADDR_W-1:0] row_caddr   [max_rows];
   logic [`SET_DATA_W-1:0] row_hdata   [max_rows];
   logic [`SET_DATA_W-1:0] row_cdata   [max_rows];
   logic [3:0]             row_status  [max_rows];  // run_tx, run_rx, clk_status, link_up
   logic                   row_pps     [max_rows];
   logic [`RB_SEL_W-1:0]   row_rb_sel  [max_rows];
   logic [1:0]             row_rb_mode [max_rows];
   logic [13:0]            exp_ctrl    [max_rows];
   logic [`LED_W-1:0]      exp_leds    [max_rows];
   logic [`SET_DATA_W-1:0] exp_rb      [max_rows];

   int          n_rows;
   int          checks;
   int          errors;
   logic        table_ready;
   logic [31:0] lcg_state;

   // Reference model state
   logic [4:0]  m_clk;
   logic [3:0]  m_ser, m_adc;
   logic        m_phy, m_pps_arm, m_pps_seen, m_pend;
   logic [7:0]  m_led_sw, m_led_src;
   logic [31:0] m_hi, m_pd;
   logic [63:0] m_time, m_pps_val, m_pps_time;
   logic [`SET_ADDR_W-1:0] m_pa;

   radio_ctrl_top i_dut (.*);

   initial begin
      forever #(clk_period / 2) dsp_clk = ~dsp_clk;
   end

   function logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Mapped control registers and a few holes in the map
   function automatic logic [`SET_ADDR_W-1:0] pick_addr(input logic [31:0] r);
      case (r % 32'd11)
         32'd0:   return a_clk;
         32'd1:   return a_ser;
         32'd2:   return a_adc;
         32'd3:   return a_led;
         32'd4:   return a_phy;
         32'd5:   return a_led_src;
         32'd6:   return `SET_ADDR_W'(5);
         32'd7:   return `SET_ADDR_W'(7);
         32'd8:   return `SET_ADDR_W'(9);
         32'd9:   return `SET_ADDR_W'(13);
         default: return `SET_ADDR_W'(8'h80);
      endcase
   endfunction

   task automatic add_row(input logic [1:0] src, input logic [`SET_ADDR_W-1:0] haddr,
         input logic [`SET_ADDR_W-1:0] caddr, input logic [3:0] status, input logic pps,
         input logic [`RB_SEL_W-1:0] rb_sel, input logic [1:0] rb_mode);
      row_src[n_rows]     = src;
      row_haddr[n_rows]   = haddr;
      row_caddr[n_rows]   = caddr;
      row_hdata[n_rows]   = next_rand();
      row_cdata[n_rows]   = next_rand();
      row_status[n_rows]  = status;
      row_pps[n_rows]     = pps;
      row_rb_sel[n_rows]  = rb_sel;
      row_rb_mode[n_rows] = rb_mode;
      n_rows++;
   endtask

   task automatic add_idle(input logic [3:0] status, input logic pps,
         input logic [`RB_SEL_W-1:0] rb_sel, input logic [1:0] rb_mode);
      add_row(src_idle, '0, '0, status, pps, rb_sel, rb_mode);
   endtask

   task automatic build_table();
      logic [31:0]            r;
      logic [1:0]             src;
      logic                   prev_host;
      logic [`SET_ADDR_W-1:0] addr;
      prev_host = 1'b0;
      // Reset values followed by software LEDs and a new source mask
      add_idle(4'b1111, 1'b0, 4'd0, rb_exact);
      add_idle(4'b1010, 1'b0, 4'd3, rb_exact);
      add_row(src_host, a_led, '0, 4'b0101, 1'b0, 4'd0, rb_exact);
      add_row(src_cmd, '0, a_led_src, 4'b0011, 1'b0, 4'd0, rb_exact);
      add_idle(4'b1100, 1'b0, 4'd0, rb_exact);
      add_idle(4'b0110, 1'b0, 4'd0, rb_exact);
      // Random writes with the host never strobing two cycles running
      repeat (24) begin
         r   = next_rand();
         src = (r[1:0] == 2'd3) ? src_idle : r[1:0];
         if (src == src_host && prev_host) begin
            src = src_cmd;
         end
         addr = pick_addr(r >> 8);
         add_row(src, addr, addr, r[7:4], 1'b0, 4'(r[27:24] % 4'd10), rb_exact);
         prev_host = (src == src_host);
      end
      // Collisions on different registers and then on the same one
      add_idle(4'b0000, 1'b0, 4'd12, rb_exact);
      add_row(src_both, a_ser, a_adc, 4'b0000, 1'b0, 4'd0, rb_exact);
      add_idle(4'b0000, 1'b0, 4'd0, rb_exact);
      add_row(src_both, a_clk, a_clk, 4'b0000, 1'b0, 4'd0, rb_exact);
      add_idle(4'b0000, 1'b0, 4'd0, rb_exact);
      // Immediate load with the low word kept clear of a carry into the high word
      add_row(src_cmd, '0, a_time_hi, 4'b0000, 1'b0, 4'd0, rb_exact);
      add_row(src_host, a_time_lo_now, '0, 4'b0000, 1'b0, 4'd0, rb_exact);
      row_hdata[n_rows - 1][31] = 1'b0;
      add_idle(4'b0010, 1'b0, 4'd12, rb_exact);
      add_idle(4'b0011, 1'b0, 4'd13, rb_exact);
      add_idle(4'b0000, 1'b0, 4'd11, rb_window);
      add_idle(4'b0000, 1'b0, 4'd10, rb_exact);
      // Load armed for the next PPS edge
      add_row(src_host, a_time_hi, '0, 4'b0000, 1'b0, 4'd0, rb_exact);
      add_row(src_cmd, '0, a_time_lo_pps, 4'b0000, 1'b0, 4'd0, rb_exact);
      row_cdata[n_rows - 1][31] = 1'b0;
      repeat (5) begin
         add_idle(4'b0000, 1'b1, 4'd13, rb_exact);
      end
      add_idle(4'b0000, 1'b1, 4'd15, rb_exact);
      add_idle(4'b0000, 1'b1, 4'd14, rb_exact);
      add_idle(4'b0011, 1'b1, 4'd13, rb_exact);
      add_idle(4'b0000, 1'b1, 4'd11, rb_at_least);
   endtask

   task automatic apply_write(input logic [`SET_ADDR_W-1:0] addr, input logic [31:0] data);
      case (addr)
         a_clk:         m_clk = data[4:0];
         a_ser:         m_ser = data[3:0];
         a_adc:         m_adc = data[3:0];
         a_led:         m_led_sw = data[7:0];
         a_phy:         m_phy = data[0];
         a_led_src:     m_led_src = data[7:0];
         a_time_hi:     m_hi = data;
         a_time_lo_now: m_time = {m_hi, data};
         a_time_lo_pps: begin
            m_pps_val = {m_hi, data};
            m_pps_arm = 1'b1;
         end
         default: ;
      endcase
   endtask

   ////////////////////////////////////////////////////////////
   // Reference model that fills the expected columns of the table

   task automatic build_expected();
      int                pps_cnt;
      logic [`LED_W-1:0] hw;
      pps_cnt    = 0;
      {m_clk, m_ser, m_adc, m_phy, m_led_sw, m_pend} = '0;
      {m_pps_arm, m_pps_seen, m_time, m_pps_time} = '0;
      m_led_src = `LED_SRC_RESET;
      for (int i = 0; i < n_rows; i++) begin
         // Readback registers what the edge sees before it updates
         case (row_rb_sel[i])
            4'd10:   exp_rb[i] = m_time[63:32];
            4'd11:   exp_rb[i] = m_time[31:0];
            4'd12:   exp_rb[i] = `COMPAT_NUM;
            4'd13:   exp_rb[i] = (32'(row_status[i][1]) << 12) |
                                 (32'(row_status[i][0]) << 10) | 32'(m_pps_seen);
            4'd14:   exp_rb[i] = m_pps_time[63:32];
            4'd15:   exp_rb[i] = m_pps_time[31:0];
            default: exp_rb[i] = '0;
         endcase
         // Command wins and a colliding host write lands one cycle later
         if (row_src[i][1]) begin
            apply_write(row_caddr[i], row_cdata[i]);
         end
         if (row_src[i] == src_both) begin
            m_pend = 1'b1;
            m_pa   = row_haddr[i];
            m_pd   = row_hdata[i];
         end else if (m_pend) begin
            apply_write(m_pa, m_pd);
            m_pend = 1'b0;
         end else if (row_src[i][0]) begin
            apply_write(row_haddr[i], row_hdata[i]);
         end
         // PPS edge acts on the third edge after the input rises
         if (row_pps[i]) begin
            pps_cnt++;
            if (pps_cnt == 3) begin
               if (m_pps_arm) begin
                  m_time     = m_pps_val;
                  m_pps_time = m_pps_val;
                  m_pps_arm  = 1'b0;
               end
               m_pps_seen = 1'b1;
            end
         end
         hw          = {3'b000, row_status[i], 1'b0};
         exp_ctrl[i] = {m_clk, m_ser, m_adc, ~m_phy};
         // Each LED picks hardware or software by its own source bit
         for (int b = 0; b < `LED_W; b++) begin
            if (m_led_src[b]) begin
               exp_leds[i][b] = hw[b];
            end else begin
               exp_leds[i][b] = m_led_sw[b];
            end
         end
      end
   endtask

   task automatic drive_row(input int i);
      host_stb_i  = row_src[i][0];
      host_addr_i = row_haddr[i];
      host_data_i = row_hdata[i];
      cmd_stb_i   = row_src[i][1];
      cmd_addr_i  = row_caddr[i];
      cmd_data_i  = row_cdata[i];
      {run_tx_i, run_rx_i, clk_status_i, link_up_i} = row_status[i];
      pps_i       = row_pps[i];
      rb_sel_i    = row_rb_sel[i];
   endtask

   task automatic check_val(input string name, input int row, input logic [31:0] got,
         input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL row %0d %s: got %h expected %h", row, name, got, exp);
      end
   endtask

   task automatic check_row(input int i);
      logic [31:0] diff;
      check_val("{clock_ready_o,clk_en_o,clk_sel_o}", i,
         32'({clock_ready_o, clk_en_o, clk_sel_o}), 32'(exp_ctrl[i][13:9]));
      check_val("{ser_enable_o,ser_prbsen_o,ser_loopen_o,ser_rx_en_o}", i,
         32'({ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o}), 32'(exp_ctrl[i][8:5]));
      check_val("{adc_oe_a_o,adc_on_a_o,adc_oe_b_o,adc_on_b_o}", i,
         32'({adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}), 32'(exp_ctrl[i][4:1]));
      check_val("phy_reset_n_o", i, 32'(phy_reset_n_o), 32'(exp_ctrl[i][0]));
      check_val("leds_o", i, 32'(leds_o), 32'(exp_leds[i]));
      case (row_rb_mode[i])
         rb_window: begin
            diff = rb_data_o - exp_rb[i];
            checks++;
            if (diff < 32'd2 || diff > 32'd4) begin
               errors++;
               $display("FAIL row %0d rb_data_o: got %h expected %h plus 2 to 4",
                  i, rb_data_o, exp_rb[i]);
            end
         end
         rb_at_least: begin
            checks++;
            if (rb_data_o < exp_rb[i]) begin
               errors++;
               $display("FAIL row %0d rb_data_o: got %h expected at least %h",
                  i, rb_data_o, exp_rb[i]);
            end
         end
         default: check_val("rb_data_o", i, rb_data_o, exp_rb[i]);
      endcase
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence and watchdog

   initial begin
      por_rst     = 1'b1;
      table_ready = 1'b0;
      n_rows      = 0;
      checks      = 0;
      errors      = 0;
      lcg_state   = 32'h65c4_fac9;
      {host_stb_i, host_addr_i, host_data_i, cmd_stb_i, cmd_addr_i, cmd_data_i} = '0;
      {pps_i, clk_status_i, link_up_i, run_tx_i, run_rx_i, rb_sel_i} = '0;
      build_table();
      build_expected();
      table_ready = 1'b1;
      repeat (16) @(negedge dsp_clk);
      por_rst = 1'b0;
      for (int i = 0; i < n_rows; i++) begin
         @(negedge dsp_clk);
         if (i > 0) begin
            check_row(i - 1);
         end
         drive_row(i);
      end
      @(negedge dsp_clk);
      check_row(n_rows - 1);
      $display("Checks: %0d  errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   initial begin
      wait (table_ready);
      #((n_rows + 50) * 10 * clk_period);
      $display("Timeout: the table of %0d rows did not finish in time", n_rows);
      $display("Checks: %0d  errors: %0d", checks, errors);
      $display("Verification failed");
      $finish;
   end

endmodule

// File: build.f
+incdir+.
radio_pkg.sv
settings_ctrl.sv
misc_regs.sv
vita_timer.sv
readback_mux.sv
radio_ctrl_top.sv
radio_ctrl_tb.sv

// File: Makefile
# Verilator lint and simulation of the settings-bus core

TOOL     = verilator
FLAGS    = --timing --assert
TOP      = radio_ctrl_tb
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Verification failed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || { cat $(LOG); exit 1; }
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
